/* design/ccd_defines.svh */
// Sizing of the camera video path, shared by the package and the RTL
// LINE_MAX must be even and at least the widest raw line the sensor sends

`ifndef CCD_DEFINES_SVH
`define CCD_DEFINES_SVH

// ==========================================================================
// Sensor side
// ==========================================================================
`define RAW_W        12    // Raw Bayer sample bits
`define COORD_W      12    // Column and row counters
`define LINE_MAX     1280  // Line buffer depth in raw columns
`define FRAME_CNT_W  16    // Captured frame counter, wraps

// ==========================================================================
// Frame buffer word
// ==========================================================================
`define COMP5_W      5     // Per channel field in RGB mode
`define LEVEL_W      8     // Binary level, brightness and threshold

`endif

/* design/ccd_pkg.sv */
// Types shared along the camera path, one sample or pixel per clock
// Frame buffer word is fixed at 16 bits, both views must stay that wide

`include "ccd_defines.svh"

package ccd_pkg;

  // ==========================================================================
  // Stream items between stages
  // ==========================================================================

  // One raw sample with its position in the frame
  typedef struct packed {
    logic                  valid;  // Sample captured this cycle
    logic [`RAW_W-1:0]     data;   // Bayer value as sent by the sensor
    logic [`COORD_W-1:0]   col;    // Raw column, 0 at line start
    logic [`COORD_W-1:0]   row;    // Raw row, 0 at frame start
  } raw_sample_t;

  // Reconstructed pixel at half resolution
  typedef struct packed {
    logic                  valid;
    logic [`RAW_W-1:0]     red;
    logic [`RAW_W-1:0]     green;  // Mean of both greens, truncated
    logic [`RAW_W-1:0]     blue;
  } rgb_pixel_t;

  // ==========================================================================
  // Frame buffer word, read as colour or as binary level
  // ==========================================================================

  typedef struct packed {
    logic                  pad;    // Always 0
    logic [`COMP5_W-1:0]   r5;
    logic [`COMP5_W-1:0]   g5;
    logic [`COMP5_W-1:0]   b5;
  } fb_rgb555_t;

  typedef struct packed {
    logic [`LEVEL_W-1:0]   pad;    // Always 0
    logic [`LEVEL_W-1:0]   level;  // 0 or 255
  } fb_mono_t;

  typedef union packed {
    fb_rgb555_t            rgb555; // RGB mode
    fb_mono_t              mono;   // Binary mode
  } fb_word_u;

endpackage

/* design/sensor_capture.sv */
// Sensor pins are assumed synchronous to ccd_pixel_clk, no extra synchronizer
// Capture starts and stops only on frame boundaries, counters follow lval/fval

`timescale 1ns/1ns

`include "ccd_defines.svh"

module sensor_capture
  import ccd_pkg::*;
(
  input  logic                    ccd_pixel_clk,
  input  logic                    arst_n,
  input  logic [`RAW_W-1:0]       ccd_data,
  input  logic                    ccd_fval,
  input  logic                    ccd_lval,
  input  logic                    capture_start,  // Level, checked at frame edges
  output raw_sample_t             sample,
  output logic [`FRAME_CNT_W-1:0] frame_count
);

  // ==========================================================================
  // Pin registers and edge detection
  // ==========================================================================
  logic [`RAW_W-1:0] data_q;     // Payload, no reset
  logic              fval_q;
  logic              lval_q;
  logic              fval_prev;
  logic              lval_prev;

  always_ff @(posedge ccd_pixel_clk) begin
    data_q <= ccd_data;
  end

  always_ff @(posedge ccd_pixel_clk or negedge arst_n) begin
    if (!arst_n) begin
      fval_q    <= 1'b0;
      lval_q    <= 1'b0;
      fval_prev <= 1'b0;
      lval_prev <= 1'b0;
    end else begin
      fval_q    <= ccd_fval;
      lval_q    <= ccd_lval;
      fval_prev <= fval_q;
      lval_prev <= lval_q;
    end
  end

  logic fval_rise;
  logic fval_fall;
  logic line_end;

  assign fval_rise = fval_q & ~fval_prev;
  assign fval_fall = ~fval_q & fval_prev;
  assign line_end  = ~lval_q & lval_prev;

  // ==========================================================================
  // Capture enable and counters
  // ==========================================================================
  logic                    capture_en;
  logic                    capture_on;   // Also true in the fval rise cycle
  logic                    sample_hit;
  logic [`COORD_W-1:0]     col_cnt;
  logic [`COORD_W-1:0]     row_cnt;
  logic [`COORD_W-1:0]     row_cur;      // Row seen by a sample this cycle

  assign capture_on = capture_en | (fval_rise & capture_start);
  assign sample_hit = fval_q & lval_q & capture_on;
  assign row_cur    = fval_rise ? '0 : row_cnt;

  always_ff @(posedge ccd_pixel_clk or negedge arst_n) begin
    if (!arst_n) begin
      capture_en  <= 1'b0;
      col_cnt     <= '0;
      row_cnt     <= '0;
      frame_count <= '0;
    end else begin
      if (fval_rise && capture_start)
        capture_en <= 1'b1;
      else if (fval_fall && !capture_start)
        capture_en <= 1'b0;               // Frame just ended, stop here

      if (line_end)
        col_cnt <= '0;
      else if (sample_hit)
        col_cnt <= col_cnt + 1'b1;

      if (fval_rise)
        row_cnt <= '0;                    // New frame
      else if (line_end && col_cnt != '0)
        row_cnt <= row_cnt + 1'b1;        // Only lines that held samples

      if (fval_fall && capture_en)
        frame_count <= frame_count + 1'b1;
    end
  end

  // ==========================================================================
  // Sample register, second stage after the pins
  // ==========================================================================
  logic                valid_q;
  logic [`RAW_W-1:0]   sdata_q;
  logic [`COORD_W-1:0] col_q;
  logic [`COORD_W-1:0] row_q;

  always_ff @(posedge ccd_pixel_clk or negedge arst_n) begin
    if (!arst_n) valid_q <= 1'b0;
    else         valid_q <= sample_hit;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    sdata_q <= data_q;
    col_q   <= col_cnt;   // Value before this sample's increment
    row_q   <= row_cur;
  end

  assign sample = '{valid: valid_q, data: sdata_q, col: col_q, row: row_q};

endmodule

/* design/bayer_demosaic.sv */
// Expects G1 R / B G2 ordering with the frame starting on an even row
// Lines wider than LINE_MAX raw columns alias in the line buffer

`timescale 1ns/1ns

`include "ccd_defines.svh"

module bayer_demosaic
  import ccd_pkg::*;
(
  input  logic        ccd_pixel_clk,
  input  logic        arst_n,
  input  raw_sample_t sample,
  output rgb_pixel_t  pixel
);

  localparam int LB_AW = $clog2(`LINE_MAX);  // Line buffer address bits

  // ==========================================================================
  // Position decode
  // ==========================================================================
  logic odd_row;
  logic odd_col;
  logic wr_even_row;   // G1 or R sample, goes to the buffer
  logic hold_b;        // B sample, kept for the next cycle
  logic emit;          // G2 sample closes a 2x2 cell

  assign odd_row     = sample.row[0];
  assign odd_col     = sample.col[0];
  assign wr_even_row = sample.valid & ~odd_row;
  assign hold_b      = sample.valid & odd_row & ~odd_col;
  assign emit        = sample.valid & odd_row & odd_col;

  logic [LB_AW-1:0] col_addr;   // Own column, R when reading
  logic [LB_AW-1:0] g1_addr;    // Even partner of the pair

  assign col_addr = sample.col[LB_AW-1:0];
  assign g1_addr  = {sample.col[LB_AW-1:1], 1'b0};

  // ==========================================================================
  // Line buffer for the even row
  // ==========================================================================
  logic [`RAW_W-1:0] line_buf [`LINE_MAX];

  // Written on even rows, read on odd rows, never both at once
  always_ff @(posedge ccd_pixel_clk) begin
    if (wr_even_row)
      line_buf[col_addr] <= sample.data;
  end

  logic [`RAW_W-1:0] g1_rd;
  logic [`RAW_W-1:0] r_rd;

  assign g1_rd = line_buf[g1_addr];
  assign r_rd  = line_buf[col_addr];

  // ==========================================================================
  // B hold register
  // ==========================================================================
  logic [`RAW_W-1:0] b_hold;

  always_ff @(posedge ccd_pixel_clk) begin
    if (hold_b)
      b_hold <= sample.data;
  end

  // ==========================================================================
  // Green average and output register
  // ==========================================================================
  logic [`RAW_W:0]   green_sum;   // One extra bit for the carry
  logic [`RAW_W-1:0] green_avg;

  assign green_sum = {1'b0, g1_rd} + {1'b0, sample.data};
  assign green_avg = green_sum[`RAW_W:1];   // Divide by two, truncated

  logic              pix_valid;
  logic [`RAW_W-1:0] red_q;
  logic [`RAW_W-1:0] green_q;
  logic [`RAW_W-1:0] blue_q;

  always_ff @(posedge ccd_pixel_clk or negedge arst_n) begin
    if (!arst_n) pix_valid <= 1'b0;
    else         pix_valid <= emit;
  end

  // Payload only moves when a pixel is emitted
  always_ff @(posedge ccd_pixel_clk) begin
    if (emit) begin
      red_q   <= r_rd;
      green_q <= green_avg;
      blue_q  <= b_hold;
    end
  end

  assign pixel = '{valid: pix_valid, red: red_q, green: green_q, blue: blue_q};

endmodule

/* design/pixel_packer.sv */
// Mode and threshold are sampled with each pixel, changes apply mid frame
// Brightness is the largest top byte of the three channels

`timescale 1ns/1ns

`include "ccd_defines.svh"

module pixel_packer
  import ccd_pkg::*;
(
  input  logic                ccd_pixel_clk,
  input  logic                arst_n,
  input  rgb_pixel_t          pixel,
  input  logic                rgb_mode,       // 1 colour, 0 binary
  input  logic [`LEVEL_W-1:0] bri_threshold,
  output fb_word_u            fb_word,
  output logic                fb_write
);

  // ==========================================================================
  // Brightness and threshold
  // ==========================================================================
  logic [`LEVEL_W-1:0] r8;
  logic [`LEVEL_W-1:0] g8;
  logic [`LEVEL_W-1:0] b8;
  logic [`LEVEL_W-1:0] max_rg;
  logic [`LEVEL_W-1:0] bright;
  logic                white;

  assign r8     = pixel.red[`RAW_W-1 -: `LEVEL_W];
  assign g8     = pixel.green[`RAW_W-1 -: `LEVEL_W];
  assign b8     = pixel.blue[`RAW_W-1 -: `LEVEL_W];
  assign max_rg = (r8 > g8) ? r8 : g8;
  assign bright = (max_rg > b8) ? max_rg : b8;
  assign white  = (bright >= bri_threshold);   // Threshold 0 is always white

  // ==========================================================================
  // Word build, one view of the union per mode
  // ==========================================================================
  fb_word_u word_nxt;

  always_comb begin
    word_nxt = '0;                        // Pad bits stay clear
    if (rgb_mode) begin
      word_nxt.rgb555.r5 = pixel.red[`RAW_W-1 -: `COMP5_W];
      word_nxt.rgb555.g5 = pixel.green[`RAW_W-1 -: `COMP5_W];
      word_nxt.rgb555.b5 = pixel.blue[`RAW_W-1 -: `COMP5_W];
    end else begin
      word_nxt.mono.level = white ? '1 : '0;
    end
  end

  always_ff @(posedge ccd_pixel_clk or negedge arst_n) begin
    if (!arst_n) begin
      fb_word  <= '0;
      fb_write <= 1'b0;
    end else begin
      fb_write <= pixel.valid;
      if (pixel.valid)
        fb_word <= word_nxt;              // Holds last word between strobes
    end
  end

endmodule

/* design/ccd_pipeline_top.sv */
// Single clock camera path, sensor pins in, frame buffer words out
// No back-pressure, the consumer must take every fb_write strobe

`timescale 1ns/1ns

`include "ccd_defines.svh"

module ccd_pipeline_top
  import ccd_pkg::*;
(
  input  logic                    ccd_pixel_clk,
  input  logic                    arst_n,
  // Sensor pins
  input  logic [`RAW_W-1:0]       ccd_data,
  input  logic                    ccd_fval,
  input  logic                    ccd_lval,
  // Control
  input  logic                    capture_start,
  input  logic                    rgb_mode,
  input  logic [`LEVEL_W-1:0]     bri_threshold,
  // Frame buffer side
  output fb_word_u                fb_word,
  output logic                    fb_write,
  output logic [`FRAME_CNT_W-1:0] frame_count
);

  // ==========================================================================
  // Stage links
  // ==========================================================================
  raw_sample_t raw_sample;   // Capture to demosaic
  rgb_pixel_t  rgb_pixel;    // Demosaic to packer

  // Pins to raw samples, 2 cycles
  sensor_capture i_sensor_capture (
    .ccd_pixel_clk (ccd_pixel_clk),
    .arst_n        (arst_n),
    .ccd_data      (ccd_data),
    .ccd_fval      (ccd_fval),
    .ccd_lval      (ccd_lval),
    .capture_start (capture_start),
    .sample        (raw_sample),
    .frame_count   (frame_count)
  );

  // Raw to half resolution RGB, 1 cycle from G2
  bayer_demosaic i_bayer_demosaic (
    .ccd_pixel_clk (ccd_pixel_clk),
    .arst_n        (arst_n),
    .sample        (raw_sample),
    .pixel         (rgb_pixel)
  );

  // RGB to frame buffer word, 1 cycle
  pixel_packer i_pixel_packer (
    .ccd_pixel_clk (ccd_pixel_clk),
    .arst_n        (arst_n),
    .pixel         (rgb_pixel),
    .rgb_mode      (rgb_mode),
    .bri_threshold (bri_threshold),
    .fb_word       (fb_word),
    .fb_write      (fb_write)
  );

endmodule

/* tb/ccd_pipeline_properties.sv */
// Bound to ccd_pipeline_top and watches its ports only
// Capture arming is inferred from fval and capture_start seen high together

`timescale 1ns/1ns

`include "ccd_defines.svh"

module ccd_pipeline_properties (
  input logic                    ccd_pixel_clk,
  input logic                    arst_n,
  input logic                    ccd_fval,
  input logic                    capture_start,
  input logic                    fb_write,
  input logic [`FRAME_CNT_W-1:0] frame_count
);

  localparam logic [`FRAME_CNT_W-1:0] COUNT_STEP = 1;

  // Set once a frame ran with start high, the only way capture turns on
  logic armed;

  always_ff @(posedge ccd_pixel_clk or negedge arst_n) begin
    if (!arst_n)
      armed <= 1'b0;
    else if (ccd_fval && capture_start)
      armed <= 1'b1;
  end

  // ==========================================================================
  // Port checks
  // ==========================================================================
  no_write_in_reset: assert property (@(posedge ccd_pixel_clk) !arst_n |-> !fb_write)
    else $error("fb_write is high while arst_n is low");

  write_needs_capture: assert property (@(posedge ccd_pixel_clk) disable iff (!arst_n)
    fb_write |-> armed)
    else $error("fb_write is high although capture was never enabled");

  count_steps_by_one: assert property (@(posedge ccd_pixel_clk) disable iff (!arst_n)
    (frame_count != $past(frame_count)) |-> (frame_count == $past(frame_count) + COUNT_STEP))
    else $error("frame_count changed by more than one");

endmodule

bind ccd_pipeline_top ccd_pipeline_properties i_ccd_pipeline_properties (
  .ccd_pixel_clk (ccd_pixel_clk),
  .arst_n        (arst_n),
  .ccd_fval      (ccd_fval),
  .capture_start (capture_start),
  .fb_write      (fb_write),
  .frame_count   (frame_count)
);

/* tb/ccd_pipeline_tb.sv */
// Frames come from a table, pixel data from $urandom with a fixed seed
// Inputs change on the falling edge, outputs are read there too

`timescale 1ns/1ns

`include "ccd_defines.svh"

module ccd_pipeline_tb
  import ccd_pkg::*;
();

  localparam int RESET_CYCLES = 16;
  localparam int VBLANK       = 2;    // fval high before the first line
  localparam int HBLANK       = 4;    // lval low between lines
  localparam int FRAME_GAP    = 10;   // Covers the 4 cycle pipeline tail
  localparam int MARGIN       = 200;
  localparam int NUM_FRAMES   = 8;

  typedef struct packed {
    int                      width;      // Raw columns, even
    int                      rows;       // Raw rows, even
    logic                    rgb_mode;
    logic [`LEVEL_W-1:0]     threshold;
    logic                    cap_start;  // capture_start at fval rise
    logic                    cap_mid;    // From the middle row to fval fall
    logic [`FRAME_CNT_W-1:0] exp_count;  // frame_count after the frame
  } frame_cfg_t;

  // ==========================================================================
  // DUT and clock
  // ==========================================================================
  logic                    ccd_pixel_clk;
  logic                    arst_n;
  logic [`RAW_W-1:0]       ccd_data;
  logic                    ccd_fval;
  logic                    ccd_lval;
  logic                    capture_start;
  logic                    rgb_mode;
  logic [`LEVEL_W-1:0]     bri_threshold;
  fb_word_u                fb_word;
  logic                    fb_write;
  logic [`FRAME_CNT_W-1:0] frame_count;

  ccd_pipeline_top i_ccd_pipeline_top (
    .ccd_pixel_clk (ccd_pixel_clk),
    .arst_n        (arst_n),
    .ccd_data      (ccd_data),
    .ccd_fval      (ccd_fval),
    .ccd_lval      (ccd_lval),
    .capture_start (capture_start),
    .rgb_mode      (rgb_mode),
    .bri_threshold (bri_threshold),
    .fb_word       (fb_word),
    .fb_write      (fb_write),
    .frame_count   (frame_count)
  );

  always #20 ccd_pixel_clk = ~ccd_pixel_clk;   // 40 ns period

  frame_cfg_t  frames [NUM_FRAMES];
  fb_word_u    exp_q [$];          // Expected words in write order
  logic        cap_en_ref = 1'b0;  // Capture state as the rules give it
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  // ==========================================================================
  // Failure handling and compare tasks
  // ==========================================================================
  task automatic halt_on_failure();
    $display("Something failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_word(input fb_word_u got, input fb_word_u exp);
    if (got !== exp) begin
      $display("error at %0t ns: fb_word is %h, expected %h", $time, got, exp);
      halt_on_failure();
    end
  endtask

  task automatic check_count(input logic [`FRAME_CNT_W-1:0] got,
                             input logic [`FRAME_CNT_W-1:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: frame_count is %0d, expected %0d", $time, got, exp);
      halt_on_failure();
    end
  endtask

  // ==========================================================================
  // Reference model
  // ==========================================================================

  // One 2x2 cell to the frame buffer word
  function automatic fb_word_u expected_word(
    input logic [`RAW_W-1:0]   red,
    input logic [`RAW_W-1:0]   g1,
    input logic [`RAW_W-1:0]   g2,
    input logic [`RAW_W-1:0]   blue,
    input logic                mode,
    input logic [`LEVEL_W-1:0] thr
  );
    int                  gmean;
    logic [`RAW_W-1:0]   green;
    logic [`LEVEL_W-1:0] peak;
    fb_word_u            w;
    gmean = (int'(g1) + int'(g2)) / 2;      // Mean, truncated
    green = gmean[`RAW_W-1:0];
    if (mode) begin
      w = {1'b0, red[`RAW_W-1 -: `COMP5_W], green[`RAW_W-1 -: `COMP5_W],
           blue[`RAW_W-1 -: `COMP5_W]};
    end else begin
      peak = red[`RAW_W-1 -: `LEVEL_W];
      if (green[`RAW_W-1 -: `LEVEL_W] > peak)
        peak = green[`RAW_W-1 -: `LEVEL_W];
      if (blue[`RAW_W-1 -: `LEVEL_W] > peak)
        peak = blue[`RAW_W-1 -: `LEVEL_W];
      w = {8'h00, ((peak >= thr) ? 8'hff : 8'h00)};
    end
    return w;
  endfunction

  function automatic int frame_cycles(input frame_cfg_t cfg);
    return 1 + VBLANK + cfg.rows * (cfg.width + HBLANK) + FRAME_GAP;
  endfunction

  // ==========================================================================
  // Frame driver
  // ==========================================================================
  task automatic run_frame(input frame_cfg_t cfg);
    logic [31:0]       rnd;
    logic [`RAW_W-1:0] d;
    logic [`RAW_W-1:0] b_held;
    logic [`RAW_W-1:0] even_line [$];   // G1 R row seen by the model
    logic              captured;
    rgb_mode      = cfg.rgb_mode;
    bri_threshold = cfg.threshold;
    capture_start = cfg.cap_start;
    b_held        = '0;
    @(negedge ccd_pixel_clk);
    ccd_fval = 1'b1;
    captured = cap_en_ref | cfg.cap_start;   // Only whole frames
    repeat (VBLANK) @(negedge ccd_pixel_clk);
    for (int r = 0; r < cfg.rows; r++) begin
      if (r == cfg.rows / 2)
        capture_start = cfg.cap_mid;        // Mid frame start/stop
      if (r % 2 == 0)
        even_line.delete();
      for (int c = 0; c < cfg.width; c++) begin
        rnd      = $urandom();
        d        = rnd[`RAW_W-1:0];
        ccd_lval = 1'b1;
        ccd_data = d;
        if (captured) begin
          if (r % 2 == 0)
            even_line.push_back(d);         // G1 or R
          else if (c % 2 == 0)
            b_held = d;
          else
            exp_q.push_back(expected_word(even_line[c], even_line[c-1], d, b_held,
                                          cfg.rgb_mode, cfg.threshold));
        end
        @(negedge ccd_pixel_clk);
      end
      ccd_lval = 1'b0;
      repeat (HBLANK) @(negedge ccd_pixel_clk);
    end
    ccd_fval   = 1'b0;
    cap_en_ref = cfg.cap_mid ? captured : 1'b0;   // Stop only at fval fall
    repeat (FRAME_GAP) @(negedge ccd_pixel_clk);
    check_count(frame_count, cfg.exp_count);
    if (exp_q.size() != 0) begin
      $display("%0d words of the last frame were not written in time", exp_q.size());
      halt_on_failure();
    end
  endtask

  // ==========================================================================
  // Output monitor and timeout
  // ==========================================================================
  always @(negedge ccd_pixel_clk) begin
    if (arst_n && fb_write) begin
      if (exp_q.size() == 0) begin
        $display("fb_write came at %0t ns with no word expected", $time);
        halt_on_failure();
      end else begin
        check_word(fb_word, exp_q.pop_front());
      end
    end
  end

  always @(posedge ccd_pixel_clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout, the run took more than %0d cycles", cycle_limit);
      halt_on_failure();
    end
  end

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    void'($urandom(32'h46f0_e2e5));

    //         width rows rgb  thr     start mid   count
    frames = '{'{ 8, 4, 1'b1, 8'd0,   1'b0, 1'b0, 16'd0},   // Capture off
               '{16, 6, 1'b1, 8'd0,   1'b1, 1'b1, 16'd1},   // RGB
               '{12, 4, 1'b0, 8'd0,   1'b1, 1'b1, 16'd2},   // All white
               '{12, 4, 1'b0, 8'd128, 1'b1, 1'b1, 16'd3},
               '{12, 4, 1'b0, 8'd255, 1'b1, 1'b0, 16'd4},   // Stop mid frame
               '{10, 4, 1'b1, 8'd0,   1'b0, 1'b1, 16'd4},   // Start mid frame
               '{20, 8, 1'b1, 8'd0,   1'b1, 1'b1, 16'd5},
               '{ 8, 2, 1'b0, 8'd200, 1'b1, 1'b1, 16'd6}};

    cycle_limit = RESET_CYCLES + MARGIN;
    foreach (frames[i])
      cycle_limit += frame_cycles(frames[i]);

    ccd_pixel_clk = 1'b0;
    arst_n        = 1'b0;
    ccd_data      = '0;
    ccd_fval      = 1'b0;
    ccd_lval      = 1'b0;
    capture_start = 1'b0;
    rgb_mode      = 1'b1;
    bri_threshold = '0;

    repeat (RESET_CYCLES) @(negedge ccd_pixel_clk);
    arst_n = 1'b1;
    repeat (2) @(negedge ccd_pixel_clk);

    foreach (frames[i])
      run_frame(frames[i]);

    if (exp_q.size() != 0) begin
      $display("%0d expected words were never written", exp_q.size());
      halt_on_failure();
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

/* vlog.f */
+incdir+design
design/ccd_pkg.sv
design/sensor_capture.sv
design/bayer_demosaic.sv
design/pixel_packer.sv
design/ccd_pipeline_top.sv
tb/ccd_pipeline_properties.sv
tb/ccd_pipeline_tb.sv

/* run.sh */
#!/bin/sh
# Builds the camera pipeline testbench with Verilator and runs it.
# The exit status is the simulator's own: non-zero when the run fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f \
  --top-module ccd_pipeline_tb -Mdir obj_dir -o ccd_pipeline_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/ccd_pipeline_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0
